// ==== hw/ooo_pkg.sv ====
package ooo_pkg;

  // physical register space
  localparam int num_tags  = 32;
  localparam int tag_width = $clog2(num_tags); // 5 bits for 32 tags

  typedef logic [tag_width-1:0] tag_t;  // physical register index
  typedef logic [15:0]          data_t; // register value

  // kind of execution unit an entry is tied to
  typedef enum logic {
    fu_alu  = 1'b0,
    fu_mult = 1'b1
  } fu_type_t;

  // operation carried from dispatch through to the unit
  typedef enum logic [2:0] {
    func_add = 3'd0,
    func_sub = 3'd1,
    func_and = 3'd2,
    func_xor = 3'd3,
    func_mul = 3'd4 // low 16 bits of product
  } alu_func_t;

  // unit population, one station entry per unit
  localparam int num_fu = 3;

  // entry/unit index -> kind
  // 0 and 1 are single cycle alus, 2 is the pipelined multiplier
  localparam fu_type_t fu_list [num_fu] = '{
    fu_alu,
    fu_alu,
    fu_mult
  };

  // issue to done, in cycles, with no back-pressure
  localparam int alu_latency  = 1;
  localparam int mult_latency = 3;

endpackage

// ==== hw/reservation_station.sv ====
`timescale 1ns/1ns

module reservation_station (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       dispatch_en,
  input  ooo_pkg::fu_type_t          dispatch_fu,
  input  ooo_pkg::alu_func_t         dispatch_func,
  input  ooo_pkg::tag_t              dest_tag,
  input  ooo_pkg::tag_t              src1_tag,
  input  logic                       src1_ready,
  input  ooo_pkg::tag_t              src2_tag,
  input  logic                       src2_ready,
  input  logic [ooo_pkg::num_fu-1:0] fu_ready,
  input  logic                       cdb_valid,
  input  ooo_pkg::tag_t              cdb_tag,
  output logic                       rs_hazard,
  output logic [ooo_pkg::num_fu-1:0] issue_valid,
  output ooo_pkg::alu_func_t         issue_func [ooo_pkg::num_fu],
  output ooo_pkg::tag_t              issue_dest [ooo_pkg::num_fu],
  output ooo_pkg::tag_t              issue_src1 [ooo_pkg::num_fu],
  output ooo_pkg::tag_t              issue_src2 [ooo_pkg::num_fu]
);
  import ooo_pkg::*;

  // entry storage, entry i feeds unit i
  logic      [num_fu-1:0] busy;
  alu_func_t              ent_func [num_fu];
  tag_t                   ent_dest [num_fu];
  tag_t                   ent_src1 [num_fu];
  tag_t                   ent_src2 [num_fu];
  logic      [num_fu-1:0] ent_rdy1; // source 1 value already in regfile
  logic      [num_fu-1:0] ent_rdy2;

  logic [num_fu-1:0] wake1;   // cdb hits source 1 this cycle
  logic [num_fu-1:0] wake2;
  logic [num_fu-1:0] ok1;     // source 1 usable now (stored or bypassed)
  logic [num_fu-1:0] ok2;
  logic [num_fu-1:0] issuing; // handshake with unit completes
  logic [num_fu-1:0] free;    // entry can take a dispatch this cycle
  logic [num_fu-1:0] match;   // free and of the requested kind
  logic [num_fu-1:0] alloc;   // one-hot, entry written at the edge
  logic              in_rdy1; // incoming source 1 ready, incl. same cycle cdb
  logic              in_rdy2;

  // wakeup, issue request and free detection per entry
  always_comb begin
    for (int i = 0; i < num_fu; i++) begin
      wake1[i]       = cdb_valid && (cdb_tag == ent_src1[i]);
      wake2[i]       = cdb_valid && (cdb_tag == ent_src2[i]);
      ok1[i]         = ent_rdy1[i] || wake1[i];
      ok2[i]         = ent_rdy2[i] || wake2[i];
      issue_valid[i] = busy[i] && ok1[i] && ok2[i]; // stale tags masked by busy
      issuing[i]     = issue_valid[i] && fu_ready[i];
      free[i]        = !busy[i] || issuing[i];      // slot vacated this cycle counts
      match[i]       = free[i] && (fu_list[i] == dispatch_fu);
    end
  end

  // hazard when nothing of the requested kind can take the op
  assign rs_hazard = ~|match;

  // lowest matching entry wins
  always_comb begin
    alloc = '0;
    for (int i = 0; i < num_fu; i++) begin
      if (dispatch_en && match[i] && (alloc == '0)) begin
        alloc[i] = 1'b1;
      end
    end
  end

  // a source broadcast in the dispatch cycle would otherwise be missed
  assign in_rdy1 = src1_ready || (cdb_valid && (cdb_tag == src1_tag));
  assign in_rdy2 = src2_ready || (cdb_valid && (cdb_tag == src2_tag));

  // issue bundle straight from the entry
  assign issue_func = ent_func;
  assign issue_dest = ent_dest;
  assign issue_src1 = ent_src1; // also the regfile read address
  assign issue_src2 = ent_src2;

  // busy bits
  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= '0;
    end else begin
      busy <= (busy & ~issuing) | alloc; // alloc wins over a same cycle issue
    end
  end

  // entry payload and ready bits, only meaningful while busy
  always_ff @(posedge clock) begin
    for (int i = 0; i < num_fu; i++) begin
      if (alloc[i]) begin
        ent_func[i] <= dispatch_func;
        ent_dest[i] <= dest_tag;
        ent_src1[i] <= src1_tag;
        ent_src2[i] <= src2_tag;
        ent_rdy1[i] <= in_rdy1;
        ent_rdy2[i] <= in_rdy2;
      end else begin
        // cdb sets ready bits, they never clear while waiting
        if (wake1[i]) begin
          ent_rdy1[i] <= 1'b1;
        end
        if (wake2[i]) begin
          ent_rdy2[i] <= 1'b1;
        end
      end
    end
  end

endmodule

// ==== hw/phys_regfile.sv ====
`timescale 1ns/1ns

module phys_regfile (
  input  logic           clock,
  input  logic           reset,
  input  logic           fill_en,
  input  ooo_pkg::tag_t  fill_tag,
  input  ooo_pkg::data_t fill_value,
  input  logic           cdb_valid,
  input  ooo_pkg::tag_t  cdb_tag,
  input  ooo_pkg::data_t cdb_value,
  input  ooo_pkg::tag_t  rd_tag1 [ooo_pkg::num_fu],
  input  ooo_pkg::tag_t  rd_tag2 [ooo_pkg::num_fu],
  output ooo_pkg::data_t rd_data1 [ooo_pkg::num_fu],
  output ooo_pkg::data_t rd_data2 [ooo_pkg::num_fu]
);
  import ooo_pkg::*;

  data_t regs [num_tags]; // one value per physical tag

  logic [num_fu-1:0] hit1; // cdb carries the tag being read on port 1
  logic [num_fu-1:0] hit2;

  // two write ports, the later assignment (cdb) wins on a tag clash
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int r = 0; r < num_tags; r++) begin
        regs[r] <= '0;
      end
    end else begin
      if (fill_en) begin
        regs[fill_tag] <= fill_value; // initial state, no broadcast
      end
      if (cdb_valid) begin
        regs[cdb_tag] <= cdb_value;
      end
    end
  end

  // combinational operand read, one pair per unit
  always_comb begin
    for (int i = 0; i < num_fu; i++) begin
      hit1[i] = cdb_valid && (cdb_tag == rd_tag1[i]);
      hit2[i] = cdb_valid && (cdb_tag == rd_tag2[i]);

      // same cycle forward lets a woken entry issue with the broadcast value
      rd_data1[i] = hit1[i] ? cdb_value : regs[rd_tag1[i]];
      rd_data2[i] = hit2[i] ? cdb_value : regs[rd_tag2[i]];
    end
  end

endmodule

// ==== hw/func_unit.sv ====
`timescale 1ns/1ns

module func_unit #(
  parameter int LATENCY = 1
) (
  input  logic               clock,
  input  logic               reset,
  input  logic               issue_valid,
  input  ooo_pkg::alu_func_t issue_func,
  input  ooo_pkg::tag_t      issue_dest,
  input  ooo_pkg::data_t     op1,
  input  ooo_pkg::data_t     op2,
  input  logic               grant,
  output logic               fu_ready,
  output logic               done,
  output ooo_pkg::tag_t      done_tag,
  output ooo_pkg::data_t     done_value
);
  import ooo_pkg::*;

  localparam int last = LATENCY - 1; // holding stage facing the cdb

  logic  [LATENCY-1:0] stage_valid;
  tag_t                stage_tag [LATENCY];
  data_t               stage_value [LATENCY];
  logic  [LATENCY-1:0] accept; // stage k can be loaded at the edge
  data_t               result; // computed on entry

  // whole computation happens at issue, later stages only carry it
  always_comb begin
    case (issue_func)
      func_add: result = op1 + op2;
      func_sub: result = op1 - op2;
      func_and: result = op1 & op2;
      func_xor: result = op1 ^ op2;
      func_mul: result = op1 * op2; // 16 bit context keeps the low half
      default:  result = '0;
    endcase
  end

  // a stage accepts when empty or when its own content moves on
  always_comb begin
    accept[last] = !stage_valid[last] || grant; // held until the arbiter picks us
    for (int k = last - 1; k >= 0; k--) begin
      accept[k] = !stage_valid[k] || accept[k+1];
    end
  end

  assign fu_ready = accept[0];

  // valid bits
  always_ff @(posedge clock) begin
    if (reset) begin
      stage_valid <= '0;
    end else begin
      if (accept[0]) begin
        stage_valid[0] <= issue_valid;
      end
      for (int k = 1; k < LATENCY; k++) begin
        if (accept[k]) begin
          stage_valid[k] <= stage_valid[k-1]; // bubble moves in if upstream empty
        end
      end
    end
  end

  // tag and result ride alongside
  always_ff @(posedge clock) begin
    if (issue_valid && accept[0]) begin
      stage_tag[0]   <= issue_dest;
      stage_value[0] <= result;
    end
    for (int k = 1; k < LATENCY; k++) begin
      if (accept[k] && stage_valid[k-1]) begin
        stage_tag[k]   <= stage_tag[k-1];
        stage_value[k] <= stage_value[k-1];
      end
    end
  end

  assign done       = stage_valid[last];
  assign done_tag   = stage_tag[last];
  assign done_value = stage_value[last];

endmodule

// ==== hw/cdb_arbiter.sv ====
`timescale 1ns/1ns

module cdb_arbiter (
  input  logic [ooo_pkg::num_fu-1:0] done,
  input  ooo_pkg::tag_t              done_tag [ooo_pkg::num_fu],
  input  ooo_pkg::data_t             done_value [ooo_pkg::num_fu],
  output logic [ooo_pkg::num_fu-1:0] grant,
  output logic                       cdb_valid,
  output ooo_pkg::tag_t              cdb_tag,
  output ooo_pkg::data_t             cdb_value
);
  import ooo_pkg::*;

  logic [num_fu-1:0] lower_done; // some lower index unit is already done

  // prefix of done from unit 0 upward
  always_comb begin
    lower_done[0] = 1'b0;
    for (int i = 1; i < num_fu; i++) begin
      lower_done[i] = lower_done[i-1] || done[i-1];
    end
  end

  // unit 0 has highest priority
  always_comb begin
    for (int i = 0; i < num_fu; i++) begin
      grant[i] = done[i] && !lower_done[i];
    end
  end

  assign cdb_valid = |done; // one broadcast per cycle at most

  // one-hot mux onto the bus
  // idle bus drives zeros
  always_comb begin
    cdb_tag   = '0;
    cdb_value = '0;
    for (int i = 0; i < num_fu; i++) begin
      if (grant[i]) begin
        cdb_tag   = done_tag[i];
        cdb_value = done_value[i];
      end
    end
  end

endmodule

// ==== hw/issue_core.sv ====
`timescale 1ns/1ns

module issue_core (
  input  logic               clock,
  input  logic               reset,
  input  logic               dispatch_en,
  input  ooo_pkg::fu_type_t  dispatch_fu,
  input  ooo_pkg::alu_func_t dispatch_func,
  input  ooo_pkg::tag_t      dest_tag,
  input  ooo_pkg::tag_t      src1_tag,
  input  ooo_pkg::tag_t      src2_tag,
  input  logic               src1_ready,
  input  logic               src2_ready,
  input  logic               fill_en,
  input  ooo_pkg::tag_t      fill_tag,
  input  ooo_pkg::data_t     fill_value,
  output logic               rs_hazard,
  output logic               cdb_valid,
  output ooo_pkg::tag_t      cdb_tag,
  output ooo_pkg::data_t     cdb_value
);
  import ooo_pkg::*;

  // station to units
  logic      [num_fu-1:0] issue_valid;
  logic      [num_fu-1:0] fu_ready;
  alu_func_t              issue_func [num_fu];
  tag_t                   issue_dest [num_fu];
  tag_t                   issue_src1 [num_fu]; // regfile read address
  tag_t                   issue_src2 [num_fu];
  data_t                  op1 [num_fu];        // regfile to units, same cycle
  data_t                  op2 [num_fu];

  // units to arbiter
  logic      [num_fu-1:0] done;
  logic      [num_fu-1:0] grant;
  tag_t                   done_tag [num_fu];
  data_t                  done_value [num_fu];

  reservation_station reservation_station_i (
    .clock         (clock),
    .reset         (reset),
    .dispatch_en   (dispatch_en),
    .dispatch_fu   (dispatch_fu),
    .dispatch_func (dispatch_func),
    .dest_tag      (dest_tag),
    .src1_tag      (src1_tag),
    .src1_ready    (src1_ready),
    .src2_tag      (src2_tag),
    .src2_ready    (src2_ready),
    .fu_ready      (fu_ready),
    .cdb_valid     (cdb_valid),
    .cdb_tag       (cdb_tag),
    .rs_hazard     (rs_hazard),
    .issue_valid   (issue_valid),
    .issue_func    (issue_func),
    .issue_dest    (issue_dest),
    .issue_src1    (issue_src1),
    .issue_src2    (issue_src2)
  );

  phys_regfile phys_regfile_i (
    .clock      (clock),
    .reset      (reset),
    .fill_en    (fill_en),
    .fill_tag   (fill_tag),
    .fill_value (fill_value),
    .cdb_valid  (cdb_valid),
    .cdb_tag    (cdb_tag),
    .cdb_value  (cdb_value),
    .rd_tag1    (issue_src1),
    .rd_tag2    (issue_src2),
    .rd_data1   (op1),
    .rd_data2   (op2)
  );

  // one unit per entry, depth picked from its kind
  for (genvar i = 0; i < num_fu; i++) begin : g_fu
    func_unit #(
      .LATENCY ((fu_list[i] == fu_mult) ? mult_latency : alu_latency)
    ) func_unit_i (
      .clock       (clock),
      .reset       (reset),
      .issue_valid (issue_valid[i]),
      .issue_func  (issue_func[i]),
      .issue_dest  (issue_dest[i]),
      .op1         (op1[i]),
      .op2         (op2[i]),
      .grant       (grant[i]),
      .fu_ready    (fu_ready[i]),
      .done        (done[i]),
      .done_tag    (done_tag[i]),
      .done_value  (done_value[i])
    );
  end

  cdb_arbiter cdb_arbiter_i (
    .done       (done),
    .done_tag   (done_tag),
    .done_value (done_value),
    .grant      (grant),
    .cdb_valid  (cdb_valid),
    .cdb_tag    (cdb_tag),
    .cdb_value  (cdb_value)
  );

endmodule

// ==== verification/issue_core_asserts.sv ====
`timescale 1ns/1ns

module issue_core_asserts (
  input logic                       clock,
  input logic                       reset,
  input logic                       dispatch_en,
  input logic                       rs_hazard,
  input logic                       cdb_valid,
  input logic [ooo_pkg::num_fu-1:0] done,
  input logic [ooo_pkg::num_fu-1:0] grant,
  input ooo_pkg::tag_t              done_tag [ooo_pkg::num_fu],
  input ooo_pkg::data_t             done_value [ooo_pkg::num_fu]
);
  import ooo_pkg::*;

  // the bus carries one result at most
  a_one_grant: assert property (@(posedge clock) disable iff (reset) $onehot0(grant))
    else $error("more than one unit granted the cdb");

  // second reset edge onward, pipes are flushed
  a_idle_reset: assert property (@(posedge clock) reset && $past(reset) |-> !cdb_valid)
    else $error("cdb valid while in reset");

  a_no_hazard_dispatch: assert property (@(posedge clock) disable iff (reset)
    rs_hazard |-> !dispatch_en)
    else $error("dispatch strobed while the station reports a hazard");

  // a result waiting for the bus must not change under it
  for (genvar i = 0; i < num_fu; i++) begin : g_hold
    a_done_held: assert property (@(posedge clock) disable iff (reset)
      done[i] && !grant[i] |=> done[i] && $stable(done_tag[i]) && $stable(done_value[i]))
      else $error("unit %0d dropped or changed a held result", i);
  end

endmodule

bind issue_core issue_core_asserts issue_core_asserts_i (
  .clock       (clock),
  .reset       (reset),
  .dispatch_en (dispatch_en),
  .rs_hazard   (rs_hazard),
  .cdb_valid   (cdb_valid),
  .done        (done),
  .grant       (grant),
  .done_tag    (done_tag),
  .done_value  (done_value)
);

// ==== verification/issue_core_tb.sv ====
`timescale 1ns/1ns

module issue_core_tb;
  import ooo_pkg::*;

  localparam int total_ops = 215; // directed ops plus the random mix

  logic clock = 1'b0;
  logic reset, dispatch_en, src1_ready, src2_ready, fill_en, rs_hazard, cdb_valid;
  fu_type_t dispatch_fu;
  alu_func_t dispatch_func;
  tag_t dest_tag, src1_tag, src2_tag, fill_tag, cdb_tag;
  data_t fill_value, cdb_value;

  integer seed = 92;
  data_t model [num_tags];     // value each tag will finally hold
  data_t expected [num_tags];  // result awaited on the cdb
  tag_t rec_src1 [num_tags];
  tag_t rec_src2 [num_tags];
  logic outstanding [num_tags];
  int src_uses [num_tags];     // pending readers, blocks reuse as a destination
  logic hazard_seen;
  tag_t t0, t1, t2, t3;

  issue_core issue_core_i (.*);

  always #4 clock = ~clock;

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic compare_tag(input string name, input tag_t act, input tag_t exp);
    if (act !== exp) fail_now($sformatf("MISMATCH t=%0t %s got %0d expected %0d",
                                        $time, name, act, exp));
  endtask

  task automatic compare_data(input string name, input data_t act, input data_t exp);
    if (act !== exp) fail_now($sformatf("MISMATCH t=%0t %s got %h expected %h",
                                        $time, name, act, exp));
  endtask

  task automatic compare_bit(input string name, input logic act, input logic exp);
    if (act !== exp) fail_now($sformatf("MISMATCH t=%0t %s got %b expected %b",
                                        $time, name, act, exp));
  endtask

  function automatic data_t ref_result(input alu_func_t f, input data_t a, input data_t b);
    data_t p;
    case (f)
      func_add: p = a + b;
      func_sub: p = a - b;
      func_and: p = a & b;
      func_xor: p = a ^ b;
      default:  p = a * b; // low half only
    endcase
    return p;
  endfunction

  // some op still waits for its result
  function automatic logic any_pending();
    logic p;
    p = 1'b0;
    for (int t = 0; t < num_tags; t++) begin
      p |= outstanding[t];
    end
    return p;
  endfunction

  // lowest tag still awaiting its result
  function automatic tag_t first_pending();
    for (int k = 0; k < num_tags; k++) begin
      if (outstanding[k]) begin
        return tag_t'(k);
      end
    end
    return '0;
  endfunction

  // free destination: nothing pending writes or reads it
  function automatic logic find_dest(input tag_t s1, input tag_t s2, output tag_t d);
    int start;
    tag_t c;
    start = $random(seed);
    for (int k = 0; k < num_tags; k++) begin
      c = tag_t'(start + k);
      if (!outstanding[c] && src_uses[c] == 0 && c != s1 && c != s2) begin
        d = c;
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // called 1 ns after an edge, returns 1 ns after the accepting edge
  task automatic dispatch_op(input fu_type_t fu, input alu_func_t f, input tag_t s1,
                             input tag_t s2, output tag_t d);
    logic go;
    while (!find_dest(s1, s2, d)) begin
      @(posedge clock);
      #1;
    end
    go = 1'b0;
    while (!go) begin
      dispatch_fu   = fu;
      dispatch_func = f;
      dest_tag      = d;
      src1_tag      = s1;
      src2_tag      = s2;
      src1_ready    = !outstanding[s1]; // producers may finish while we wait
      src2_ready    = !outstanding[s2];
      #1;
      if (rs_hazard) begin
        hazard_seen = 1'b1;
        @(posedge clock);
        #1;
      end else begin
        go = 1'b1;
      end
    end
    dispatch_en = 1'b1;
    expected[d] = ref_result(f, model[s1], model[s2]);
    model[d]    = expected[d];
    rec_src1[d] = s1;
    rec_src2[d] = s2;
    outstanding[d] = 1'b1;
    src_uses[s1]++;
    src_uses[s2]++;
    @(posedge clock);
    #1;
    dispatch_en = 1'b0;
  endtask

  function automatic tag_t rand_tag();
    return tag_t'($random(seed));
  endfunction

  function automatic alu_func_t rand_alu();
    return alu_func_t'(($random(seed) & 32'h7fff_ffff) % 4);
  endfunction

  task automatic drain();
    for (int n = 0; n < 200; n++) begin
      if (!any_pending()) return;
      @(posedge clock);
      #1;
    end
  endtask

  // every broadcast must retire exactly one pending op
  always @(posedge clock) begin
    if (!reset && cdb_valid) begin
      compare_bit("cdb_valid", cdb_valid, any_pending());
      // an awaited tag passes as itself, anything else against the oldest awaited one
      compare_tag("cdb_tag", cdb_tag, outstanding[cdb_tag] ? cdb_tag : first_pending());
      compare_data("cdb_value", cdb_value, expected[cdb_tag]);
      outstanding[cdb_tag] = 1'b0;
      src_uses[rec_src1[cdb_tag]]--;
      src_uses[rec_src2[cdb_tag]]--;
    end
  end

  initial begin
    #((16 + 200 * total_ops) * 8);
    fail_now("watchdog expired before the test sequence completed");
  end

  initial begin
    reset = 1'b1;
    dispatch_en = 1'b0;
    fill_en = 1'b0;
    hazard_seen = 1'b0;
    dispatch_fu = fu_alu;
    dispatch_func = func_add;
    dest_tag = '0;
    src1_tag = '0;
    src2_tag = '0;
    src1_ready = 1'b0;
    src2_ready = 1'b0;
    fill_tag = '0;
    fill_value = '0;
    for (int t = 0; t < num_tags; t++) begin
      model[t] = '0;
      outstanding[t] = 1'b0;
      src_uses[t] = 0;
    end
    repeat (16) @(posedge clock);
    #1 reset = 1'b0;

    // idle bus, then load every register
    for (int t = 0; t < num_tags; t++) begin
      compare_bit("cdb_valid", cdb_valid, 1'b0);
      compare_bit("rs_hazard", rs_hazard, 1'b0);
      fill_en = 1'b1;
      fill_tag = tag_t'(t);
      fill_value = data_t'($random(seed));
      model[t] = fill_value;
      @(posedge clock);
      #1;
    end
    fill_en = 1'b0;

    dispatch_op(fu_alu, func_add, 5'd1, 5'd2, t0); // independent ops
    dispatch_op(fu_alu, func_xor, 5'd3, 5'd4, t1);
    dispatch_op(fu_mult, func_mul, 5'd5, 5'd6, t2);
    dispatch_op(fu_alu, func_sub, 5'd7, 5'd8, t3);
    drain();

    dispatch_op(fu_mult, func_mul, 5'd9, 5'd10, t0); // chain through wakeup
    dispatch_op(fu_alu, func_add, t0, 5'd11, t1);
    dispatch_op(fu_mult, func_mul, t1, t0, t2);
    dispatch_op(fu_alu, func_sub, t2, t1, t3);
    drain();

    hazard_seen = 1'b0; // both alu entries stall on a slow producer
    dispatch_op(fu_mult, func_mul, 5'd12, 5'd13, t0);
    dispatch_op(fu_alu, func_and, t0, 5'd14, t1);
    dispatch_op(fu_alu, func_xor, 5'd15, t0, t2);
    dispatch_op(fu_alu, func_add, 5'd16, 5'd17, t3);
    if (!hazard_seen) fail_now("third alu dispatch never saw a station hazard");
    drain();

    dispatch_op(fu_mult, func_mul, 5'd18, 5'd19, t0); // results collide
    dispatch_op(fu_alu, func_add, 5'd20, 5'd21, t1);
    dispatch_op(fu_alu, func_sub, 5'd22, 5'd23, t2);
    drain();

    for (int n = 0; n < 200; n++) begin
      if (($random(seed) & 3) == 0) dispatch_op(fu_mult, func_mul, rand_tag(), rand_tag(), t0);
      else dispatch_op(fu_alu, rand_alu(), rand_tag(), rand_tag(), t0);
    end
    drain();

    if (any_pending()) begin
      fail_now($sformatf("tag %0d never completed on the cdb", first_pending()));
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

// ==== vlog.f ====
hw/ooo_pkg.sv
hw/reservation_station.sv
hw/phys_regfile.sv
hw/func_unit.sv
hw/cdb_arbiter.sv
hw/issue_core.sv
verification/issue_core_asserts.sv
verification/issue_core_tb.sv
